//--- logic/uartLinePkg.sv
// line-side definitions for the serial peripheral
//  receiver and transmitter state enums
//  frame shape and oversampling ratio
package uartLinePkg;

	//////////////////////////////////////////////////
	// frame constants
	//////////////////////////////////////////////////
	localparam int frameDataBits = 8;	// data bits per frame, LSB first
	localparam int ticksPerBit = 16;	// 16x oversampling

	// receiver states, 2 bits
	typedef enum logic [1:0] {
		rxIdle, rxStart, rxData, rxStop
	} rxState_t;

	// transmitter states, 2 bits
	typedef enum logic [1:0] {
		txIdle, txStart, txData, txStop
	} txState_t;

endpackage

//--- logic/uartBusPkg.sv
// processor-side definitions for the serial peripheral
//  command set seen by the processor
//  bit positions inside the status byte
package uartBusPkg;

	//////////////////////////////////////////////////
	// commands
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {
		cmdRead,	// pop rx FIFO, return head byte
		cmdWrite,	// push tx FIFO, return old status
		cmdStatus	// return status, clear rx overrun
	} uartCmd_t;

	// status byte layout, upper bits read zero
	localparam int statRxNotEmpty = 0;
	localparam int statTxFull = 1;
	localparam int statRxOverrun = 2;
	localparam int statTxIdle = 3;	// tx FIFO empty and transmitter idle

endpackage

//--- logic/fifoPortIf.sv
`timescale 1ns/1ps
// FIFO port bundle
//  push side, pop side and flags of one byte FIFO
//  modports for the FIFO itself, its producer and its consumer
interface fifoPortIf
	import uartLinePkg::*;
#(
	parameter int width = frameDataBits
);
	logic pushValid;	// push request from producer
	logic [width-1:0] pushData;
	logic popReq;	// pop request from consumer
	logic [width-1:0] popData;	// head entry, no latency
	logic notEmpty;
	logic full;
	logic overrun;	// sticky, set on push into a full FIFO

	modport fifo (input pushValid, pushData, popReq,
		output popData, notEmpty, full, overrun);
	modport producer (output pushValid, pushData, input full, notEmpty, overrun);
	modport consumer (output popReq, input popData, notEmpty, overrun);

endinterface

//--- logic/baudTick.sv
`timescale 1ns/1ps
// baudTick
//  free-running divider for the 16x oversampling tick
//  one-cycle pulse every clksPerTick clocks
module baudTick
#(
	parameter int clksPerTick = 54
)
(
	input  logic clk,
	input  logic reset,
	output logic sTick
);
	// counter width, at least one bit
	localparam int cntW = (clksPerTick > 1) ? $clog2(clksPerTick) : 1;
	localparam logic [cntW-1:0] lastCnt = cntW'(clksPerTick - 1);

	logic [cntW-1:0] cntReg;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cntReg <= '0;
		else if (cntReg == lastCnt)
			cntReg <= '0;	// wrap
		else
			cntReg <= cntReg + 1'b1;
	end

	assign sTick = (cntReg == lastCnt);	// pulse on the wrap

endmodule

//--- logic/uartRec.sv
`timescale 1ns/1ps
// uartRec
//  16x oversampling receiver for 8N1 frames
//  start bit checked at its middle, data sampled mid-bit, LSB first
//  completed byte pushed into the receive FIFO
module uartRec
	import uartLinePkg::*;
#(
	parameter int stopTicks = 16
)
(
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic rx,
	fifoPortIf.producer rxFifo
);
	localparam int maxTicks = (stopTicks > ticksPerBit) ? stopTicks : ticksPerBit;
	localparam int sW = $clog2(maxTicks);
	localparam int nW = $clog2(frameDataBits);

	rxState_t stateReg, stateNext;
	logic [sW-1:0] sReg, sNext;	// tick counter within a bit
	logic [nW-1:0] nReg, nNext;	// data bit index
	logic [frameDataBits-1:0] bReg, bNext;	// shift register
	logic rxMeta, rxSync;	// two-flop synchronizer
	logic rxDoneTick;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;	// line idles high
			rxSync <= 1'b1;
			stateReg <= rxIdle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			rxIdle:
				if (!rxSync)	// falling edge
				begin
					stateNext = rxStart;
					sNext = '0;
				end
			rxStart:
				if (sTick)
				begin
					if (sReg == sW'(ticksPerBit / 2 - 1))
					begin
						sNext = '0;
						nNext = '0;
						// high at mid start bit means a glitch
						stateNext = rxSync ? rxIdle : rxData;
					end
					else
						sNext = sReg + 1'b1;
				end
			rxData:
				if (sTick)
				begin
					if (sReg == sW'(ticksPerBit - 1))	// middle of the next bit
					begin
						sNext = '0;
						bNext = {rxSync, bReg[frameDataBits-1:1]};	// LSB first
						if (nReg == nW'(frameDataBits - 1))
							stateNext = rxStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			rxStop:
				if (sTick)
				begin
					if (sReg == sW'(stopTicks - 1))
					begin
						stateNext = rxIdle;
						rxDoneTick = 1'b1;	// frame complete
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = rxIdle;
		endcase
	end

	assign rxFifo.pushValid = rxDoneTick;	// byte lands in the FIFO next cycle
	assign rxFifo.pushData = bReg;

endmodule

//--- logic/uartXmit.sv
`timescale 1ns/1ps
// uartXmit
//  frame transmitter fed by the transmit FIFO
//  start bit, eight data bits LSB first, stop bit
//  every bit held for a fixed number of oversampling ticks
module uartXmit
	import uartLinePkg::*;
#(
	parameter int stopTicks = 16
)
(
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	fifoPortIf.consumer txFifo,
	output logic tx,
	output logic busy
);
	localparam int maxTicks = (stopTicks > ticksPerBit) ? stopTicks : ticksPerBit;
	localparam int sW = $clog2(maxTicks);
	localparam int nW = $clog2(frameDataBits);

	txState_t stateReg, stateNext;
	logic [sW-1:0] sReg, sNext;	// tick counter
	logic [nW-1:0] nReg, nNext;	// bits sent
	logic [frameDataBits-1:0] bReg, bNext;	// outgoing byte
	logic txReg, txNext;	// registered line, no glitches

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= txIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// mark state
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = 1'b1;
		txFifo.popReq = 1'b0;
		case (stateReg)
			txIdle:
				if (txFifo.notEmpty)
				begin
					txFifo.popReq = 1'b1;	// take the head byte
					bNext = txFifo.popData;
					sNext = '0;
					stateNext = txStart;
				end
			txStart:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == sW'(ticksPerBit - 1))
					begin
						sNext = '0;
						nNext = '0;
						stateNext = txData;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txData:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == sW'(ticksPerBit - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;	// next bit to the bottom
						if (nReg == nW'(frameDataBits - 1))
							stateNext = txStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txStop:
				if (sTick)
				begin
					if (sReg == sW'(stopTicks - 1))
						stateNext = txIdle;
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = txIdle;
		endcase
	end

	assign tx = txReg;
	assign busy = (stateReg != txIdle);

endmodule

//--- logic/byteFifo.sv
`timescale 1ns/1ps
// byteFifo
//  synchronous circular byte buffer
//  notEmpty, full and sticky overrun flags
//  head entry visible on popData without delay
module byteFifo
	import uartLinePkg::*;
#(
	parameter int fifoDepth = 16	// power of two
)
(
	input  logic clk,
	input  logic reset,
	fifoPortIf.fifo port,
	input  logic clearOverrun
);
	localparam int aW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

	logic [frameDataBits-1:0] mem [fifoDepth];	// storage, no reset
	logic [aW-1:0] wrPtr, rdPtr;
	logic [aW:0] count;	// one extra bit to reach fifoDepth
	logic doPush, doPop;

	assign doPush = port.pushValid && !port.full;	// dropped when full
	assign doPop = port.popReq && port.notEmpty;	// empty pop ignored

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			port.overrun <= 1'b0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps at power of two
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + (aW+1)'(doPush) - (aW+1)'(doPop);
			if (port.pushValid && port.full)
				port.overrun <= 1'b1;	// set wins over clear
			else if (clearOverrun)
				port.overrun <= 1'b0;
		end
	end

	always_ff @(posedge clk)
		if (doPush)
			mem[wrPtr] <= port.pushData;

	assign port.popData = mem[rdPtr];
	assign port.notEmpty = (count != '0);
	assign port.full = (count == (aW+1)'(fifoDepth));

endmodule

//--- logic/uartCmdPort.sv
`timescale 1ns/1ps
// uartCmdPort
//  command decoder between processor and both FIFO paths
//  valid/ready command side, one registered response
//  status byte built from receive and transmit state
module uartCmdPort
	import uartBusPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic cmdValid,
	output logic cmdReady,
	input  uartCmd_t cmd,
	input  logic [7:0] wrData,
	output logic rspValid,
	input  logic rspReady,
	output logic [7:0] rspData,
	fifoPortIf.consumer rxFifo,
	fifoPortIf.producer txFifo,
	input  logic txBusy,
	output logic clearRxOverrun
);
	logic accept;	// command handshake this cycle
	logic [7:0] statByte;
	logic [7:0] rspNext;

	assign cmdReady = !rspValid;	// nothing pending
	assign accept = cmdValid && cmdReady;

	// side effects on the FIFOs
	assign rxFifo.popReq = accept && (cmd == cmdRead);
	assign txFifo.pushValid = accept && (cmd == cmdWrite);
	assign txFifo.pushData = wrData;
	assign clearRxOverrun = accept && (cmd == cmdStatus);

	//////////////////////////////////////////////////
	// status byte and response select
	//////////////////////////////////////////////////
	always_comb
	begin
		statByte = '0;	// upper bits read zero
		statByte[statRxNotEmpty] = rxFifo.notEmpty;
		statByte[statTxFull] = txFifo.full;
		statByte[statRxOverrun] = rxFifo.overrun;
		statByte[statTxIdle] = !txFifo.notEmpty && !txBusy;	// line drained
		case (cmd)
			cmdRead:
				rspNext = rxFifo.notEmpty ? rxFifo.popData : 8'h00;
			cmdWrite, cmdStatus:
				rspNext = statByte;	// status before this command acts
			default:
				rspNext = 8'h00;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rspValid <= 1'b0;
		else if (accept)
			rspValid <= 1'b1;
		else if (rspReady)
			rspValid <= 1'b0;	// consumed
	end

	always_ff @(posedge clk)
		if (accept)
			rspData <= rspNext;	// held under back-pressure

endmodule

//--- logic/uartPeriph.sv
`timescale 1ns/1ps
// uartPeriph
//  serial-line peripheral top level
//  tick divider, receive path, transmit path and command port
module uartPeriph
	import uartBusPkg::*;
#(
	parameter int clksPerTick = 54,
	parameter int fifoDepth = 16,
	parameter int stopTicks = 16
)
(
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	input  logic cmdValid,
	output logic cmdReady,
	input  uartCmd_t cmd,
	input  logic [7:0] wrData,
	output logic rspValid,
	input  logic rspReady,
	output logic [7:0] rspData
);
	logic sTick;	// 16x oversampling tick
	logic txBusy;
	logic clearRxOverrun;

	fifoPortIf rxIf ();	// receiver to command port
	fifoPortIf txIf ();	// command port to transmitter

	baudTick #(.clksPerTick(clksPerTick)) tickGen (.clk, .reset, .sTick);

	//////////////////////////////////////////////////
	// receive path
	//////////////////////////////////////////////////
	uartRec #(.stopTicks(stopTicks)) rec (.clk, .reset, .sTick, .rx, .rxFifo(rxIf.producer));
	byteFifo #(.fifoDepth(fifoDepth)) rxFifoU (.clk, .reset, .port(rxIf.fifo),
		.clearOverrun(clearRxOverrun));

	//////////////////////////////////////////////////
	// transmit path
	//////////////////////////////////////////////////
	byteFifo #(.fifoDepth(fifoDepth)) txFifoU (.clk, .reset, .port(txIf.fifo),
		.clearOverrun(1'b0));	// tx overrun stays sticky
	uartXmit #(.stopTicks(stopTicks)) xmit (.clk, .reset, .sTick, .txFifo(txIf.consumer),
		.tx, .busy(txBusy));

	uartCmdPort cmdPort (.clk, .reset, .cmdValid, .cmdReady, .cmd, .wrData, .rspValid,
		.rspReady, .rspData, .rxFifo(rxIf.consumer), .txFifo(txIf.producer), .txBusy,
		.clearRxOverrun);

endmodule

//--- tb/uartPeriph_assertions.sv
`timescale 1ns/1ps
// protocol checks on the peripheral's top-level ports
//  line idles high after reset
//  no command accepted while a response waits
//  response held stable under back-pressure
module uartPeriph_assertions
(
	input  logic clk,
	input  logic reset,
	input  logic tx,
	input  logic cmdReady,
	input  logic rspValid,
	input  logic rspReady,
	input  logic [7:0] rspData
);
	int failCount = 0;	// failed protocol checks

	//////////////////////////////////////////////////
	// reset values
	//////////////////////////////////////////////////
	// handshake clear on the first cycle, line high for the next ones
	property idleAfterReset;
		@(posedge clk) $fell(reset) |-> (tx && cmdReady && !rspValid) ##1 (tx [*2]);
	endproperty
	idleChk: assert property (idleAfterReset)
		else begin
			$error("line not idle or handshake not clear after reset");
			failCount++;
		end

	// pending response blocks new commands
	property readyBlocked;
		@(posedge clk) disable iff (reset) rspValid |-> !cmdReady;
	endproperty
	readyChk: assert property (readyBlocked)
		else begin
			$error("cmdReady high while a response is pending");
			failCount++;
		end

	//////////////////////////////////////////////////
	// back-pressure
	//////////////////////////////////////////////////
	property rspHeld;
		@(posedge clk) disable iff (reset)
			rspValid && !rspReady |=> rspValid && $stable(rspData);
	endproperty
	holdChk: assert property (rspHeld)
		else begin
			$error("response dropped or changed before rspReady");
			failCount++;
		end

endmodule

//--- tb/uartPeriphTb.sv
`timescale 1ns/1ps
// loopback testbench for the serial peripheral
//  clock, reset and falling-edge stimulus
//  LFSR data source and expected response queue
//  response check assertions, watchdog and summary
module uartPeriphTb
	import uartLinePkg::*, uartBusPkg::*;
();
	localparam int clksPerTick = 2;
	localparam int bitClks = ticksPerBit * clksPerTick;
	localparam int frameClks = (frameDataBits + 2) * bitClks;	// start, data, stop
	localparam int quietClks = 11 * bitClks;	// longer than any high run in a frame
	localparam int watchdogClks = 40 * frameClks + 2000;

	logic clk, reset, rx, tx;
	logic cmdValid, cmdReady, rspValid, rspReady;
	uartCmd_t cmd;
	logic [7:0] wrData, rspData;

	int errCount;
	logic [7:0] expQ [$];	// expected responses, in command order
	logic [7:0] sentQ [$];	// bytes that should come back
	logic [7:0] expHead;	// expectation for the pending response
	logic [15:0] lfsrState;

	uartPeriph #(.clksPerTick(clksPerTick), .fifoDepth(4)) uut (.clk, .reset, .rx, .tx,
		.cmdValid, .cmdReady, .cmd, .wrData, .rspValid, .rspReady, .rspData);

	bind uartPeriph uartPeriph_assertions protoChk (.clk(clk), .reset(reset), .tx(tx),
		.cmdReady(cmdReady), .rspValid(rspValid), .rspReady(rspReady), .rspData(rspData));

	assign rx = tx;	// loopback

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// response checks
	//////////////////////////////////////////////////
	rspChk: assert property (@(posedge clk) disable iff (reset)
		rspValid && rspReady |-> rspData == expHead)
		else begin
			$display("Fail rspData: expected 0x%h, actual 0x%h", expHead, $sampled(rspData));
			errCount++;
		end

	rspRise: assert property (@(posedge clk) disable iff (reset)
		cmdValid && cmdReady |=> rspValid)
		else begin
			$display("no response in the cycle after an accepted command");
			errCount++;
		end

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic takeByte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			b[i] = lfsrState[0];	// one step per bit
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	function automatic logic [7:0] statusByte(input logic rxNe, txFull, rxOvr, txIdle);
		logic [7:0] s;
		s = 8'h00;
		s[statRxNotEmpty] = rxNe;
		s[statTxFull] = txFull;
		s[statRxOverrun] = rxOvr;
		s[statTxIdle] = txIdle;
		return s;
	endfunction

	// called and returns on a falling edge
	task automatic issueCmd(input uartCmd_t c, input logic [7:0] d, input logic [7:0] exp,
		input int hold);
		int waitCnt;
		waitCnt = 0;
		expQ.push_back(exp);
		cmd = c;
		wrData = d;
		cmdValid = 1'b1;
		while (!cmdReady && waitCnt < 100)
		begin
			@(negedge clk);
			waitCnt++;
		end
		if (!cmdReady)
		begin
			$display("command never accepted, cmdReady stayed low");
			errCount++;
			cmdValid = 1'b0;
			void'(expQ.pop_back());
			return;
		end
		@(negedge clk);	// accepted on the edge before
		cmdValid = 1'b0;
		expHead = expQ.pop_front();
		if (hold > 0)
			rspReady = 1'b0;	// back-pressure
		repeat (hold) @(negedge clk);
		rspReady = 1'b1;
		@(negedge clk);
	endtask

	task automatic writeByte(input logic [7:0] expStatus, input bit lands);
		logic [7:0] b;
		takeByte(b);
		if (lands)
			sentQ.push_back(b);
		issueCmd(cmdWrite, b, expStatus, 0);
	endtask

	// all frames out once tx stays high longer than a frame
	task automatic waitLineQuiet();
		int highRun, elapsed;
		highRun = 0;
		elapsed = 0;
		while (highRun < quietClks && elapsed < 12 * frameClks)
		begin
			@(negedge clk);
			elapsed++;
			highRun = tx ? highRun + 1 : 0;
		end
		if (highRun < quietClks)
		begin
			$display("serial line never went quiet after the writes");
			errCount++;
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	initial
	begin
		int total;
		reset = 1'b1;
		cmdValid = 1'b0;
		cmd = cmdStatus;
		wrData = 8'h00;
		rspReady = 1'b1;
		errCount = 0;
		lfsrState = 16'd39;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		issueCmd(cmdStatus, 8'h00, statusByte(0, 0, 0, 1), 0);	// only tx idle
		issueCmd(cmdRead, 8'h00, 8'h00, 0);	// empty rx FIFO
		// short loopback
		writeByte(statusByte(0, 0, 0, 1), 1);
		writeByte(8'h00, 1);	// transmitter busy from here
		writeByte(8'h00, 1);
		waitLineQuiet();
		issueCmd(cmdStatus, 8'h00, statusByte(1, 0, 0, 1), 0);
		repeat (3) issueCmd(cmdRead, 8'h00, sentQ.pop_front(), 0);
		issueCmd(cmdRead, 8'h00, 8'h00, 0);
		issueCmd(cmdStatus, 8'h00, statusByte(0, 0, 0, 1), 6);	// held response
		// five bytes reach the line, last two hit a full tx FIFO
		for (int i = 0; i < 7; i++)
			writeByte((i == 0) ? statusByte(0, 0, 0, 1) : statusByte(0, i >= 5, 0, 0), i < 5);
		waitLineQuiet();
		issueCmd(cmdStatus, 8'h00, statusByte(1, 0, 1, 1), 0);	// rx overrun seen
		issueCmd(cmdStatus, 8'h00, statusByte(1, 0, 0, 1), 0);	// and cleared
		repeat (4) issueCmd(cmdRead, 8'h00, sentQ.pop_front(), 0);
		sentQ.delete();	// fifth byte dropped by the rx FIFO
		issueCmd(cmdRead, 8'h00, 8'h00, 0);
		issueCmd(cmdStatus, 8'h00, statusByte(0, 0, 0, 1), 0);
		repeat (4) @(negedge clk);
		total = errCount + uut.protoChk.failCount;
		$display("errors: %0d (response %0d, protocol %0d)", total, errCount,
			uut.protoChk.failCount);
		if (total == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (watchdogClks) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", watchdogClks);
		$display("errors: %0d", errCount + uut.protoChk.failCount);
		$display("Something failed");
		$finish;
	end

endmodule

//--- uartPeriph.f
logic/uartLinePkg.sv
logic/uartBusPkg.sv
logic/fifoPortIf.sv
logic/baudTick.sv
logic/uartRec.sv
logic/uartXmit.sv
logic/byteFifo.sv
logic/uartCmdPort.sv
logic/uartPeriph.sv
tb/uartPeriph_assertions.sv
tb/uartPeriphTb.sv

//--- Bender.yml
package:
  name: uartPeriph

sources:
  # packages and interface first
  - logic/uartLinePkg.sv
  - logic/uartBusPkg.sv
  - logic/fifoPortIf.sv
  - logic/baudTick.sv
  - logic/uartRec.sv
  - logic/uartXmit.sv
  - logic/byteFifo.sv
  - logic/uartCmdPort.sv
  - logic/uartPeriph.sv
  - target: test
    files:
      - tb/uartPeriph_assertions.sv
      - tb/uartPeriphTb.sv
